//--- source/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int data_w    = 8;
    localparam int addr_w    = 4;
    localparam int op_w      = 4;
    localparam int ram_bytes = 16;

    // microsteps per instruction, T0 to T4
    localparam int t_states = 5;
    localparam int t_w      = $clog2(t_states);

    // opcodes, upper nibble of the instruction
    localparam logic [op_w-1:0] op_lda = 4'd0;
    localparam logic [op_w-1:0] op_add = 4'd1;
    localparam logic [op_w-1:0] op_sub = 4'd2;
    localparam logic [op_w-1:0] op_sta = 4'd3;
    localparam logic [op_w-1:0] op_ldi = 4'd4;
    localparam logic [op_w-1:0] op_jmp = 4'd5;
    localparam logic [op_w-1:0] op_jc  = 4'd6;
    localparam logic [op_w-1:0] op_jz  = 4'd7;
    localparam logic [op_w-1:0] op_out = 4'd14;
    localparam logic [op_w-1:0] op_hlt = 4'd15;

    localparam int ctrl_w = 15;

    // control word fields, msb first
    // n_ prefix means active low
    typedef struct packed {
        logic cp;
        logic ep;
        logic lp;
        logic n_lma;
        logic n_lmd;
        logic n_ce;
        logic n_lr;
        logic n_li;
        logic n_ei;
        logic n_la;
        logic ea;
        logic sub;
        logic eu;
        logic n_lb;
        logic n_lo;
    } ctrl_fields_t;

    // microcode writes raw, datapath reads fields
    typedef union packed {
        logic [ctrl_w-1:0] raw;
        ctrl_fields_t      fields;
    } ctrl_word_t;

    // every field inactive
    localparam logic [ctrl_w-1:0] ctrl_idle = 15'h0FE3;

    // toggle masks, xor with ctrl_idle to assert a signal
    localparam logic [ctrl_w-1:0] m_cp    = 15'h4000;
    localparam logic [ctrl_w-1:0] m_ep    = 15'h2000;
    localparam logic [ctrl_w-1:0] m_lp    = 15'h1000;
    localparam logic [ctrl_w-1:0] m_n_lma = 15'h0800;
    localparam logic [ctrl_w-1:0] m_n_lmd = 15'h0400;
    localparam logic [ctrl_w-1:0] m_n_ce  = 15'h0200;
    localparam logic [ctrl_w-1:0] m_n_lr  = 15'h0100;
    localparam logic [ctrl_w-1:0] m_n_li  = 15'h0080;
    localparam logic [ctrl_w-1:0] m_n_ei  = 15'h0040;
    localparam logic [ctrl_w-1:0] m_n_la  = 15'h0020;
    localparam logic [ctrl_w-1:0] m_ea    = 15'h0010;
    localparam logic [ctrl_w-1:0] m_sub   = 15'h0008;
    localparam logic [ctrl_w-1:0] m_eu    = 15'h0004;
    localparam logic [ctrl_w-1:0] m_n_lb  = 15'h0002;
    localparam logic [ctrl_w-1:0] m_n_lo  = 15'h0001;

endpackage

//--- source/control_block.sv
`timescale 1ns/1ns

module control_block (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [cpu_pkg::op_w-1:0] opcode,
    input  logic                     cf,
    input  logic                     zf,
    output cpu_pkg::ctrl_word_t      ctrl,
    output logic                     halted
);
    import cpu_pkg::*;

    logic [t_w-1:0] t_state;
    logic           hlt_step;

    // HLT reaches its decode step
    assign hlt_step = (t_state == t_w'(2)) && (opcode == op_hlt);

    // ring counter T0..T4, frozen once halted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            t_state <= '0;
            halted  <= 1'b0;
        end else if (halted || hlt_step) begin
            // stays in T2 for good
            halted  <= 1'b1;
        end else if (t_state == t_w'(t_states - 1)) begin
            t_state <= '0;
        end else begin
            t_state <= t_state + 1'b1;
        end
    end

    // microcode table
    always_comb begin
        ctrl.raw = ctrl_idle;
        case (t_state)
            // fetch: pc into address register
            t_w'(0): ctrl.raw = ctrl_idle ^ (m_ep | m_n_lma);
            // ram into ir, bump pc
            t_w'(1): ctrl.raw = ctrl_idle ^ (m_n_ce | m_n_li | m_cp);
            t_w'(2): begin
                case (opcode)
                    // operand address into address register
                    op_lda, op_add, op_sub, op_sta:
                        ctrl.raw = ctrl_idle ^ (m_n_ei | m_n_lma);
                    // operand straight into A
                    op_ldi: ctrl.raw = ctrl_idle ^ (m_n_ei | m_n_la);
                    op_jmp: ctrl.raw = ctrl_idle ^ (m_n_ei | m_lp);
                    // conditional jumps fall through as a nop
                    op_jc: begin
                        if (cf) begin
                            ctrl.raw = ctrl_idle ^ (m_n_ei | m_lp);
                        end
                    end
                    op_jz: begin
                        if (zf) begin
                            ctrl.raw = ctrl_idle ^ (m_n_ei | m_lp);
                        end
                    end
                    op_out: ctrl.raw = ctrl_idle ^ (m_ea | m_n_lo);
                    // hlt and 8..13 leave the word idle
                    default: ctrl.raw = ctrl_idle;
                endcase
            end
            t_w'(3): begin
                case (opcode)
                    op_lda: ctrl.raw = ctrl_idle ^ (m_n_ce | m_n_la);
                    // operand byte into B
                    op_add, op_sub: ctrl.raw = ctrl_idle ^ (m_n_ce | m_n_lb);
                    // A into the data register
                    op_sta: ctrl.raw = ctrl_idle ^ (m_ea | m_n_lmd);
                    default: ctrl.raw = ctrl_idle;
                endcase
            end
            t_w'(4): begin
                case (opcode)
                    op_add: ctrl.raw = ctrl_idle ^ (m_eu | m_n_la);
                    op_sub: ctrl.raw = ctrl_idle ^ (m_eu | m_n_la | m_sub);
                    // commit the data register to ram
                    op_sta: ctrl.raw = ctrl_idle ^ m_n_lr;
                    default: ctrl.raw = ctrl_idle;
                endcase
            end
            default: ctrl.raw = ctrl_idle;
        endcase
    end

    // at most one bus source in any step of any opcode
    a_one_bus_driver: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.fields.ep, !ctrl.fields.n_ei, !ctrl.fields.n_ce,
                  ctrl.fields.ea, ctrl.fields.eu})
    );

    // counter never leaves T0..T4
    a_t_state_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        t_state < t_w'(t_states)
    );

endmodule

//--- source/program_counter.sv
`timescale 1ns/1ns

module program_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cp,
    input  logic                       lp,
    input  logic [cpu_pkg::addr_w-1:0] jump_addr,
    output logic [cpu_pkg::addr_w-1:0] pc
);

    // jump load beats increment
    // 15 wraps to 0 through the natural overflow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (lp) begin
            pc <= jump_addr;
        end else if (cp) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::data_w-1:0] reg_a,
    input  logic [cpu_pkg::data_w-1:0] reg_b,
    input  logic                       sub,
    input  logic                       eu,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic                       cf,
    output logic                       zf
);
    import cpu_pkg::*;

    logic [data_w-1:0] b_in;
    logic              carry_out;

    // subtract as A + ~B + 1
    assign b_in = reg_b ^ {data_w{sub}};

    assign {carry_out, result} = reg_a + b_in + {{(data_w - 1){1'b0}}, sub};

    // flags only move when the alu drives the bus
    // carry high on sub means no borrow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (eu) begin
            cf <= carry_out;
            zf <= (result == '0);
        end
    end

endmodule

//--- source/memory_unit.sv
`timescale 1ns/1ns

module memory_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::data_w-1:0] bus,
    input  logic                       n_lma,
    input  logic                       n_lmd,
    input  logic                       n_lr,
    input  logic                       prog,
    input  logic                       prog_we,
    input  logic [cpu_pkg::addr_w-1:0] prog_addr,
    input  logic [cpu_pkg::data_w-1:0] prog_data,
    output logic [cpu_pkg::data_w-1:0] data_out
);
    import cpu_pkg::*;

    logic [addr_w-1:0] mar;
    logic [data_w-1:0] mdr;
    logic [data_w-1:0] ram [ram_bytes];

    // address register, low nibble of the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (!n_lma) begin
            mar <= bus[addr_w-1:0];
        end
    end

    // data register, staging for STA
    always_ff @(posedge clk) begin
        if (!n_lmd) begin
            mdr <= bus;
        end
    end

    // two write paths
    // pins while loading, data register while running
    always_ff @(posedge clk) begin
        if (prog && prog_we) begin
            ram[prog_addr] <= prog_data;
        end else if (!n_lr) begin
            ram[mar] <= mdr;
        end
    end

    // async read off the address register
    assign data_out = ram[mar];

    // core sits in reset during program mode
    // so a bus write here would mean a broken core reset
    a_no_bus_write_in_prog: assert property (
        @(posedge clk) disable iff (!rst_n)
        prog |-> n_lr
    );

endmodule

//--- source/tt_um_ece298a_8_bit_cpu_top.sv
`timescale 1ns/1ns

module tt_um_ece298a_8_bit_cpu_top (
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);
    import cpu_pkg::*;

    // loader pins
    logic              prog;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;

    logic              core_rst_n;
    ctrl_word_t        ctrl;

    logic [data_w-1:0] bus;
    logic [data_w-1:0] reg_a;
    logic [data_w-1:0] reg_b;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] out_reg;
    logic [data_w-1:0] alu_result;
    logic [data_w-1:0] ram_data;
    logic [addr_w-1:0] pc_value;
    logic [op_w-1:0]   opcode;
    logic [addr_w-1:0] operand;
    logic              cf;
    logic              zf;
    logic              halted;

    assign prog      = uio_in[5];
    assign prog_we   = uio_in[4];
    assign prog_addr = uio_in[addr_w-1:0];

    // core held in reset while loading
    assign core_rst_n = rst_n & ~prog;

    // ir split
    assign opcode  = ir[data_w-1:addr_w];
    assign operand = ir[addr_w-1:0];

    // bus mux, priority order
    // decode guarantees one source at a time
    always_comb begin
        if (ctrl.fields.ep) begin
            bus = {{(data_w - addr_w){1'b0}}, pc_value};
        end else if (!ctrl.fields.n_ei) begin
            bus = {{(data_w - addr_w){1'b0}}, operand};
        end else if (!ctrl.fields.n_ce) begin
            bus = ram_data;
        end else if (ctrl.fields.ea) begin
            bus = reg_a;
        end else if (ctrl.fields.eu) begin
            bus = alu_result;
        end else begin
            bus = '0;
        end
    end

    // A, B, IR and output latch off the bus
    always_ff @(posedge clk) begin
        if (!core_rst_n) begin
            reg_a   <= '0;
            reg_b   <= '0;
            ir      <= '0;
            out_reg <= '0;
        end else begin
            if (!ctrl.fields.n_la) begin
                reg_a <= bus;
            end
            if (!ctrl.fields.n_lb) begin
                reg_b <= bus;
            end
            if (!ctrl.fields.n_li) begin
                ir <= bus;
            end
            if (!ctrl.fields.n_lo) begin
                out_reg <= bus;
            end
        end
    end

    control_block cb (
        .clk    (clk),
        .rst_n  (core_rst_n),
        .opcode (opcode),
        .cf     (cf),
        .zf     (zf),
        .ctrl   (ctrl),
        .halted (halted)
    );

    // jump target comes from the ir operand on the bus
    program_counter pc (
        .clk       (clk),
        .rst_n     (core_rst_n),
        .cp        (ctrl.fields.cp),
        .lp        (ctrl.fields.lp),
        .jump_addr (bus[addr_w-1:0]),
        .pc        (pc_value)
    );

    alu alu_object (
        .clk    (clk),
        .rst_n  (core_rst_n),
        .reg_a  (reg_a),
        .reg_b  (reg_b),
        .sub    (ctrl.fields.sub),
        .eu     (ctrl.fields.eu),
        .result (alu_result),
        .cf     (cf),
        .zf     (zf)
    );

    // chip reset here, the ram path has to see program mode
    memory_unit mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .n_lma     (ctrl.fields.n_lma),
        .n_lmd     (ctrl.fields.n_lmd),
        .n_lr      (ctrl.fields.n_lr),
        .prog      (prog),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (ui_in),
        .data_out  (ram_data)
    );

    // pin map
    assign uo_out  = out_reg;
    assign uio_out = {cf, halted, 6'b000000};
    // top two uio pins are outputs
    assign uio_oe  = 8'hC0;

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

    localparam int n_progs = 11;
    localparam int clk_ns  = 40;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;

    // program images, 16 bytes each
    logic [7:0]  progs [n_progs][16];
    logic [31:0] rng;
    longint      budget_ns = 0;

    // reference model results for the program being run
    logic [7:0] exp_out [32];
    int         exp_count;
    int         model_steps;
    logic       model_cf;
    int         halt_cycle;

    // run tracking
    logic       checking;
    logic [7:0] prev_out;
    logic       prev_halt;
    int         out_idx;
    int         run_cycles = 0;
    int         idle_cycles = 0;

    tt_um_ece298a_8_bit_cpu_top dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    always #(clk_ns / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [7:0] expv,
                                   input logic [7:0] actv);
        abort_run($sformatf("FAILED time=%0t signal=%s expected=0x%h actual=0x%h",
                            $time, sig, expv, actv));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    // cycles since the core left reset, and cycles spent held in reset
    always @(posedge clk) begin
        if (!rst_n || uio_in[5]) begin
            run_cycles  <= 0;
            idle_cycles <= idle_cycles + 1;
        end else begin
            run_cycles  <= run_cycles + 1;
            idle_cycles <= 0;
        end
    end

    // each change of uo_out consumes one expected value
    always @(posedge clk) begin
        prev_out  <= uo_out;
        prev_halt <= uio_out[6];
        if (!checking) begin
            out_idx <= 0;
        end else if (uo_out != prev_out) begin
            out_idx <= out_idx + 1;
        end
    end

    // core held in reset clears the output and halt
    a_idle_out: assert property (@(posedge clk) (idle_cycles >= 2) |-> (uo_out == 8'h00))
        else report_mismatch("uo_out", 8'h00, $sampled(uo_out));
    a_idle_halt: assert property (@(posedge clk) (idle_cycles >= 2) |-> !uio_out[6])
        else report_mismatch("uio_out[6]", 8'h00, {7'd0, $sampled(uio_out[6])});

    // fixed pin directions, unused uio outputs low
    a_uio_oe: assert property (@(posedge clk) uio_oe == 8'hc0)
        else report_mismatch("uio_oe", 8'hc0, $sampled(uio_oe));
    a_uio_unused: assert property (@(posedge clk) uio_out[5:0] == 6'd0)
        else report_mismatch("uio_out[5:0]", 8'h00, {2'b00, $sampled(uio_out[5:0])});

    a_out_extra: assert property (@(posedge clk) disable iff (!checking)
        (uo_out != prev_out) |-> (out_idx < exp_count))
        else abort_run("uo_out changed after the last expected output");
    a_out_value: assert property (@(posedge clk) disable iff (!checking)
        (uo_out != prev_out) |-> (uo_out == exp_out[out_idx]))
        else report_mismatch("uo_out", exp_out[$sampled(out_idx)], $sampled(uo_out));

    // halt rises exactly 5 cycles per instruction plus T0..T2 of HLT
    a_halt_not_early: assert property (@(posedge clk) disable iff (!checking)
        uio_out[6] |-> (run_cycles >= halt_cycle))
        else abort_run($sformatf("halt rose after %0d cycles, expected %0d",
                                 $sampled(run_cycles), halt_cycle));
    a_halt_on_time: assert property (@(posedge clk) disable iff (!checking)
        (run_cycles == halt_cycle) |-> uio_out[6])
        else report_mismatch("uio_out[6]", 8'h01, {7'd0, $sampled(uio_out[6])});
    a_halt_holds: assert property (@(posedge clk) disable iff (!checking)
        prev_halt |-> (uio_out[6] && uo_out == prev_out))
        else abort_run("halt dropped or uo_out moved while halted");

    // ISA rules on a private copy of the program
    task automatic run_model(input int p);
        logic [7:0] mem [16];
        logic [7:0] acc;
        logic [7:0] outv;
        logic [7:0] instr;
        logic [8:0] sum;
        logic [3:0] pc;
        logic [3:0] arg;
        logic       cf;
        logic       zf;
        logic       done;
        int         steps;
        for (int i = 0; i < 16; i++) mem[i] = progs[p][i];
        acc = 8'h00;
        outv = 8'h00;
        pc = 4'h0;
        cf = 1'b0;
        zf = 1'b0;
        done = 1'b0;
        steps = 0;
        exp_count = 0;
        while (!done && steps < 400) begin
            instr = mem[pc];
            arg = instr[3:0];
            pc = pc + 4'h1;
            case (instr[7:4])
                4'h0: acc = mem[arg];
                4'h1, 4'h2: begin
                    // subtract adds the two's complement of the operand
                    if (instr[7:4] == 4'h1)
                        sum = {1'b0, acc} + {1'b0, mem[arg]};
                    else
                        sum = {1'b0, acc} + {1'b0, ~mem[arg]} + 9'd1;
                    acc = sum[7:0];
                    cf = sum[8];
                    zf = (acc == 8'h00);
                end
                4'h3: mem[arg] = acc;
                4'h4: acc = {4'h0, arg};
                4'h5: pc = arg;
                4'h6: if (cf) pc = arg;
                4'h7: if (zf) pc = arg;
                4'he: begin
                    // only a new value is visible on the pins
                    if (acc != outv) begin
                        if (exp_count < 32) exp_out[exp_count] = acc;
                        exp_count++;
                        outv = acc;
                    end
                end
                4'hf: done = 1'b1;
                default: ;
            endcase
            if (!done) steps++;
        end
        model_steps = steps;
        model_cf = cf;
        if (!done) abort_run($sformatf("program %0d never reaches HLT in the model", p));
    endtask

    // LDA, then four ADD/SUB + OUT pairs on random data, then HLT
    task automatic make_random_program(input int p);
        for (int a = 0; a < 16; a++) progs[p][a] = 8'h00;
        for (int a = 10; a < 16; a++) begin
            rng = xorshift32(rng);
            progs[p][a] = rng[7:0];
        end
        rng = xorshift32(rng);
        progs[p][0] = {4'h0, 4'(10 + rng % 6)};
        for (int k = 0; k < 4; k++) begin
            rng = xorshift32(rng);
            progs[p][1 + 2 * k] = {(rng[16] ? 4'h1 : 4'h2), 4'(10 + rng % 6)};
            progs[p][2 + 2 * k] = 8'he0;
        end
        progs[p][9] = 8'hf0;
    endtask

    // pin loader, one byte per cycle with the strobe
    task automatic load_program(input int p);
        @(posedge clk);
        checking <= 1'b0;
        uio_in   <= 8'h20;
        ui_in    <= 8'h00;
        for (int a = 0; a < 16; a++) begin
            @(posedge clk);
            uio_in <= {4'b0011, 4'(a)};
            ui_in  <= progs[p][a];
        end
        @(posedge clk);
        uio_in <= 8'h20;
        ui_in  <= 8'h00;
        // stay in program mode long enough for the idle checks
        repeat (3) @(posedge clk);
    endtask

    task automatic run_program(input int p);
        load_program(p);
        run_model(p);
        halt_cycle = 5 * model_steps + 3;
        @(posedge clk);
        uio_in   <= 8'h00;
        checking <= 1'b1;
        while (uio_out[6] !== 1'b1) @(posedge clk);
        // output must hold while halted
        repeat (20) @(posedge clk);
        assert (out_idx == exp_count)
            else abort_run($sformatf("program %0d gave %0d of %0d expected outputs",
                                     p, out_idx, exp_count));
        assert (uio_out[7] == model_cf)
            else report_mismatch("uio_out[7]", {7'd0, model_cf}, {7'd0, uio_out[7]});
    endtask

    initial begin
        longint cycles;
        rst_n    <= 1'b0;
        ena      <= 1'b1;
        ui_in    <= 8'h00;
        uio_in   <= 8'h00;
        checking <= 1'b0;
        // arithmetic, ends on a borrowing SUB
        progs[0] = '{8'h47, 8'h1c, 8'he0, 8'h1d, 8'he0, 8'h2e, 8'he0, 8'hf0,
                     8'h00, 8'h00, 8'h00, 8'h00, 8'h20, 8'hf0, 8'h30, 8'h00};
        // STA / LDA round trip with a nop opcode, carry left high
        progs[1] = '{8'h49, 8'h2e, 8'h3f, 8'h42, 8'he0, 8'h0f, 8'he0, 8'h80,
                     8'hf0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h04, 8'haa};
        // count down 3..0 with JZ/JMP, JC skipped then taken
        progs[2] = '{8'h43, 8'he0, 8'h2e, 8'h75, 8'h51, 8'he0, 8'h2e, 8'h6a,
                     8'he0, 8'h1e, 8'h6c, 8'he0, 8'hf0, 8'h00, 8'h01, 8'h00};
        rng = 32'hcfe9_12d3;
        for (int p = 3; p < n_progs; p++) make_random_program(p);
        // load, run, halt and tail cycles per program, plus 20 percent
        cycles = 3;
        for (int p = 0; p < n_progs; p++) begin
            run_model(p);
            cycles += 5 * model_steps + 3 + 16 + 6 + 20 + 2;
        end
        budget_ns = cycles * clk_ns * 12 / 10;
        repeat (3) @(posedge clk);
        // release reset straight into program mode
        rst_n  <= 1'b1;
        uio_in <= 8'h20;
        for (int p = 0; p < n_progs; p++) run_program(p);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        wait (budget_ns != 0);
        #(budget_ns);
        abort_run("watchdog expired before all programs finished");
    end

endmodule

//--- flist.f
source/cpu_pkg.sv
source/control_block.sv
source/program_counter.sv
source/alu.sv
source/memory_unit.sv
source/tt_um_ece298a_8_bit_cpu_top.sv
sim/tb_cpu.sv
